// ==== hw/mipsParams.svh ====
/*
  core-wide sizing macros
  word width, register count, data memory depth, reset fetch address
*/

`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define MIPS_XLEN 32

// architectural registers, r0 included
`define MIPS_NREGS 32

// data memory depth in words (7-bit word address)
`define MIPS_DMEM_WORDS 128

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== hw/mipsIsaPkg.sv ====
/*
  instruction set definitions for the subset core
  opcode and funct encodings, alu operation enum, decoded control struct
*/

`default_nettype none

`include "mipsParams.svh"

package mipsIsaPkg;

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,
    OP_BEQ   = 6'b000100,
    OP_ADDI  = 6'b001000,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_t;

  // function field for r-type, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL = 6'b000000,
    FN_SRL = 6'b000010,
    FN_JR  = 6'b001000,
    FN_ADD = 6'b100000,
    FN_SUB = 6'b100010,
    FN_AND = 6'b100100,
    FN_OR  = 6'b100101,
    FN_SLT = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,  // signed compare
    ALU_SLL,
    ALU_SRL
  } aluOp_t;

  // one flat lookup result per instruction
  typedef struct packed {
    logic   regDst;       // rd instead of rt
    logic   aluSrcImm;    // opB from sign-extended immediate
    logic   memToReg;     // writeback from load data
    logic   regWrite;
    logic   memWrite;
    logic   branch;       // beq
    logic   jump;         // j, jal
    logic   jumpReg;      // jr
    logic   link;         // jal, writes pc+4 to r31
    logic   shiftAmtSel;  // opA from shamt field
    aluOp_t aluOp;
  } ctrlSig_t;

endpackage

`default_nettype wire

// ==== hw/mipsBusPkg.sv ====
/*
  bus and payload types shared across the core
  machine word, register index, writeback report, data memory request
*/

`default_nettype none

`include "mipsParams.svh"

package mipsBusPkg;

  localparam int DMEM_AW = $clog2(`MIPS_DMEM_WORDS);  // word address bits

  typedef logic [`MIPS_XLEN-1:0]          word_t;
  typedef logic [$clog2(`MIPS_NREGS)-1:0] regIdx_t;

  // register write as seen from outside, 38 bits
  typedef struct packed {
    logic    valid;   // real write, never r0
    regIdx_t regIdx;
    word_t   data;
  } wbInfo_t;

  // single-cycle sram style access, no handshake
  typedef struct packed {
    logic               wrEn;
    logic [DMEM_AW-1:0] addr;    // word index
    word_t              wrData;
  } dataReq_t;

endpackage

`default_nettype wire

// ==== hw/controlDecoder.sv ====
/*
  main decoder
  opcode plus funct to one control struct, alu op included
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module controlDecoder (
  input  mipsBusPkg::word_t    instr,
  output mipsIsaPkg::ctrlSig_t ctrl
);
  import mipsIsaPkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    ctrl       = '0;       // unknown encodings stay fully inactive
    ctrl.aluOp = ALU_ADD;
    case (opcode)
      OP_RTYPE: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          FN_ADD: ctrl.aluOp = ALU_ADD;
          FN_SUB: ctrl.aluOp = ALU_SUB;
          FN_AND: ctrl.aluOp = ALU_AND;
          FN_OR:  ctrl.aluOp = ALU_OR;
          FN_SLT: ctrl.aluOp = ALU_SLT;
          FN_SLL: begin
            ctrl.aluOp       = ALU_SLL;
            ctrl.shiftAmtSel = 1'b1;  // shamt drives opA
          end
          FN_SRL: begin
            ctrl.aluOp       = ALU_SRL;
            ctrl.shiftAmtSel = 1'b1;
          end
          FN_JR: begin
            ctrl.regDst   = 1'b0;
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg  = 1'b1;   // target from rs
          end
          default: begin
            ctrl.regDst   = 1'b0;   // bad funct acts as nop
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      OP_ADDI: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      OP_LW: begin
        ctrl.aluSrcImm = 1'b1;  // base + offset
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      OP_SW: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = ALU_SUB;  // zero flag decides
      end
      OP_J:   ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;   // r31 <= pc+4
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
/*
  general purpose register file
  r0 hardwired zero, 31 storage registers, 2 read ports, 1 write port
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module regFile (
  input  logic                clk,
  input  logic                rst,
  input  mipsBusPkg::regIdx_t rdIdxA,
  input  mipsBusPkg::regIdx_t rdIdxB,
  input  logic                wrEn,
  input  mipsBusPkg::regIdx_t wrIdx,
  input  mipsBusPkg::word_t   wrData,
  output mipsBusPkg::word_t   rdDataA,
  output mipsBusPkg::word_t   rdDataB
);
  import mipsBusPkg::*;

  word_t regs [1:`MIPS_NREGS-1];  // no storage behind r0

  // write port, r0 writes dropped here
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrIdx != '0)) begin
      regs[wrIdx] <= wrData;
    end
  end

  // combinational reads
  assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
  assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
/*
  integer alu
  add, sub, and, or, signed slt, sll, srl and the zero flag
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module alu (
  input  mipsBusPkg::word_t  opA,
  input  mipsBusPkg::word_t  opB,
  input  mipsIsaPkg::aluOp_t op,
  output mipsBusPkg::word_t  result,
  output logic               zero
);
  import mipsIsaPkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = opA + opB;  // wraps, no overflow trap
      ALU_SUB: result = opA - opB;
      ALU_AND: result = opA & opB;
      ALU_OR:  result = opA | opB;
      ALU_SLT: result = ($signed(opA) < $signed(opB)) ? `MIPS_XLEN'd1 : `MIPS_XLEN'd0;
      ALU_SLL: result = opB << opA[4:0];  // shamt in opA
      ALU_SRL: result = opB >> opA[4:0];  // zero fill
      default: result = '0;
    endcase
  end

  // used by beq after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hw/pcUnit.sv ====
/*
  program counter
  pc register, pc+4, next-pc select for branch, jump and register jump
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module pcUnit (
  input  logic                 clk,
  input  logic                 rst,
  input  mipsIsaPkg::ctrlSig_t ctrl,
  input  logic                 aluZero,
  input  mipsBusPkg::word_t    branchOffset,  // sign-extended imm16
  input  logic [25:0]          jumpTarget,
  input  mipsBusPkg::word_t    regTarget,     // rs value for jr
  output mipsBusPkg::word_t    pc,
  output mipsBusPkg::word_t    pcPlus4
);
  import mipsBusPkg::*;

  word_t pcQ;
  word_t pcNext;
  word_t branchAddr;
  word_t jumpAddr;
  logic  branchTaken;

  assign pcPlus4     = pcQ + `MIPS_XLEN'd4;
  assign branchTaken = ctrl.branch & aluZero;
  assign branchAddr  = pcPlus4 + (branchOffset << 2);  // no delay slot
  assign jumpAddr    = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], jumpTarget, 2'b00};

  // priority jr, j/jal, beq, sequential
  always_comb begin
    if (ctrl.jumpReg)  pcNext = regTarget;
    else if (ctrl.jump) pcNext = jumpAddr;
    else if (branchTaken) pcNext = branchAddr;
    else pcNext = pcPlus4;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) pcQ <= `MIPS_RESET_PC;  // held while rst is high
    else pcQ <= pcNext;
  end

  assign pc = pcQ;

endmodule

`default_nettype wire

// ==== hw/dataRam.sv ====
/*
  data memory
  word addressed array, combinational read, write on the clock edge
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module dataRam (
  input  logic                 clk,
  input  mipsBusPkg::dataReq_t req,
  output mipsBusPkg::word_t    rdata
);
  import mipsBusPkg::*;

  word_t mem [`MIPS_DMEM_WORDS];

  // power-up contents only, reset leaves them alone
  initial begin
    for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // single write port
  always_ff @(posedge clk) begin
    if (req.wrEn) begin
      mem[req.addr] <= req.wrData;
    end
  end

  // async read, same cycle as the address
  assign rdata = mem[req.addr];

endmodule

`default_nettype wire

// ==== hw/mipsCore.sv ====
/*
  single-cycle datapath
  field split, immediate and shamt extension, operand and writeback muxes,
  decoder, register file, alu and pc instances
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module mipsCore (
  input  logic                 clk,
  input  logic                 rst,
  input  mipsBusPkg::word_t    instr,
  output mipsBusPkg::word_t    instrAddr,
  output mipsBusPkg::dataReq_t dmemReq,
  input  mipsBusPkg::word_t    dmemRdata,
  output mipsBusPkg::wbInfo_t  wb
);
  import mipsBusPkg::*;
  import mipsIsaPkg::*;

  ctrlSig_t ctrl;
  regIdx_t  rsIdx, rtIdx, rdIdx, wrIdx;
  word_t    rdDataA, rdDataB;
  word_t    immExt, shamtExt;
  word_t    opA, opB;
  word_t    aluResult, wrData;
  word_t    pc, pcPlus4;
  logic     aluZero;

  // ====================================================================
  // instruction fields and extension
  // ====================================================================
  assign rsIdx    = instr[25:21];
  assign rtIdx    = instr[20:16];
  assign rdIdx    = instr[15:11];
  assign immExt   = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};  // sign extend
  assign shamtExt = {{(`MIPS_XLEN-5){1'b0}}, instr[10:6]};      // zero extend

  controlDecoder decoder_i (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // ====================================================================
  // register file and alu
  // ====================================================================
  // jal forces r31, else rd for r-type, rt otherwise
  assign wrIdx = ctrl.link ? regIdx_t'(`MIPS_NREGS - 1) :
                 ctrl.regDst ? rdIdx : rtIdx;

  regFile regFile_i (
    .clk     (clk),
    .rst     (rst),
    .rdIdxA  (rsIdx),
    .rdIdxB  (rtIdx),
    .wrEn    (ctrl.regWrite),  // r0 dropped inside
    .wrIdx   (wrIdx),
    .wrData  (wrData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  assign opA = ctrl.shiftAmtSel ? shamtExt : rdDataA;
  assign opB = ctrl.aluSrcImm ? immExt : rdDataB;

  alu alu_i (
    .opA    (opA),
    .opB    (opB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // writeback select
  assign wrData = ctrl.link ? pcPlus4 :
                  ctrl.memToReg ? dmemRdata : aluResult;

  // ====================================================================
  // fetch, memory and report
  // ====================================================================
  pcUnit pcUnit_i (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .aluZero      (aluZero),
    .branchOffset (immExt),
    .jumpTarget   (instr[25:0]),
    .regTarget    (rdDataA),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  assign instrAddr = pc;

  assign dmemReq.wrEn   = ctrl.memWrite & ~rst;            // no stores in reset
  assign dmemReq.addr   = aluResult[DMEM_AW+1:2];          // byte addr to word index
  assign dmemReq.wrData = rdDataB;

  assign wb.valid  = ctrl.regWrite & (wrIdx != '0) & ~rst;
  assign wb.regIdx = wrIdx;
  assign wb.data   = wrData;

endmodule

`default_nettype wire

// ==== hw/mipsSubsys.sv ====
/*
  top level
  core plus data memory, instruction port and writeback report outside
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module mipsSubsys (
  input  logic                clk,
  input  logic                rst,
  output mipsBusPkg::word_t   instrAddr,
  input  mipsBusPkg::word_t   instr,      // answered in the same cycle
  output mipsBusPkg::wbInfo_t wb
);
  import mipsBusPkg::*;

  dataReq_t dmemReq;
  word_t    dmemRdata;

  mipsCore core_i (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrAddr (instrAddr),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

  dataRam dataRam_i (
    .clk   (clk),
    .req   (dmemReq),
    .rdata (dmemRdata)
  );

endmodule

`default_nettype wire

// ==== bench/mipsSva.sv ====
/*
  concurrent checks bound into the core
  no writeback to r0, no store in reset, sequential pc step
*/

`timescale 1ns/1ns
`default_nettype none

module mipsSva (
  input logic                 clk,
  input logic                 rst,
  input mipsBusPkg::wbInfo_t  wb,
  input mipsBusPkg::dataReq_t dmemReq,
  input mipsIsaPkg::ctrlSig_t ctrl,
  input logic                 aluZero,
  input mipsBusPkg::word_t    pc,
  input mipsBusPkg::word_t    pcPlus4
);

  int unsigned assertFails = 0;  // failure tally
  logic        seqStep;          // no jr, no jump, no taken beq

  assign seqStep = !ctrl.jump && !ctrl.jumpReg && !(ctrl.branch && aluZero);

  wbNotR0: assert property (@(posedge clk) wb.valid |-> (wb.regIdx != '0))
    else begin
      assertFails++;
      $error("wb.valid high with regIdx 0");
    end

  noStoreInReset: assert property (@(posedge clk) rst |-> !dmemReq.wrEn)
    else begin
      assertFails++;
      $error("data memory write while rst is high");
    end

  // ====================================================================
  // fall-through fetch
  // ====================================================================
  pcSequential: assert property (@(posedge clk) disable iff (rst)
      seqStep |=> (pc == $past(pcPlus4)))
    else begin
      assertFails++;
      $error("pc did not advance by 4 on a sequential instruction");
    end

endmodule

bind mipsCore mipsSva sva_i (
  .clk     (clk),
  .rst     (rst),
  .wb      (wb),
  .dmemReq (dmemReq),
  .ctrl    (ctrl),
  .aluZero (aluZero),
  .pc      (pc),
  .pcPlus4 (pcPlus4)
);

`default_nettype wire

// ==== bench/mipsTb.sv ====
/*
  testbench for the subset core
  clock, reset, instruction server, reference model, directed tests, verdict
*/

`timescale 1ns/1ns
`default_nettype none

`include "mipsParams.svh"

module mipsTb;
  import mipsBusPkg::*;
  import mipsIsaPkg::*;

  localparam word_t NOP            = '0;   // sll r0, r0, 0
  localparam int    TOTAL_PROG_LEN = 60;   // 2 + 15 + 6 + 14 + 17 + 6, leading nops included
  localparam int    CYCLE_LIMIT    = 4 * TOTAL_PROG_LEN + 100;

  logic    clk = 1'b0;
  logic    rst = 1'b1;
  word_t   instrAddr;
  word_t   instr;
  wbInfo_t wb;

  word_t prog [64];                 // program image, word indexed
  int    progLen = 1;
  word_t refRegs [`MIPS_NREGS];     // model state
  word_t refMem [`MIPS_DMEM_WORDS];
  word_t refPc = '0;
  int    seed = 32'h0bbe_c9db;
  int    cycles = 0;
  int    wbErrors = 0;
  int    pcErrors = 0;
  int    otherErrors = 0;

  always #4 clk = ~clk;  // 8 ns period

  mipsSubsys dut_i (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .wb        (wb)
  );

  // instruction server, nop outside the program
  assign instr = (instrAddr[31:2] < 30'(progLen)) ? prog[instrAddr[7:2]] : NOP;

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ====================================================================
  // encoding and stimulus helpers
  // ====================================================================
  function automatic word_t randWord();
    return $random(seed);
  endfunction

  function automatic word_t rType(input int rs, input int rt, input int rd, input int sh,
                                  input logic [5:0] fn);
    return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t iType(input logic [5:0] op, input int rs, input int rt,
                                  input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t jType(input logic [5:0] op, input int target);
    return {op, 26'(target)};
  endfunction

  task automatic emit(input word_t w);
    prog[6'(progLen)] = w;
    progLen++;
  endtask

  task automatic checkPc(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR instrAddr: got %h expected %h", got, exp);
      pcErrors++;
    end
  endtask

  task automatic checkWb(input wbInfo_t got, input wbInfo_t exp);
    if ((got.valid !== exp.valid) ||
        (exp.valid && ((got.regIdx !== exp.regIdx) || (got.data !== exp.data)))) begin
      $display("ERROR wb at pc %h: got %h expected %h", refPc, got, exp);
      wbErrors++;
    end
  endtask

  // assert rst and start an empty program (nop at the reset pc)
  task automatic enterReset();
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < 64; i++) prog[i] = NOP;
    progLen = 1;
  endtask

  task automatic leaveReset(input word_t heldInstr);
    wbInfo_t idle;
    idle = '0;
    prog[0] = heldInstr;  // served while rst is high, must have no effect
    repeat (8) begin
      @(negedge clk);
      checkPc(instrAddr, `MIPS_RESET_PC);
      checkWb(wb, idle);
    end
    prog[0] = NOP;
    rst = 1'b0;
    for (int i = 0; i < `MIPS_NREGS; i++) refRegs[i] = '0;
    refPc = `MIPS_RESET_PC + 32'd4;  // leading nop retires in the release cycle
  endtask

  // ====================================================================
  // reference model, one instruction per call
  // ====================================================================
  task automatic modelStep(output wbInfo_t expWb, output word_t nextPc);
    word_t      w, a, b, imm, pc4, res, addr;
    logic [5:0] op, fn;
    regIdx_t    dst;
    logic       doWrite;
    w = (refPc[31:2] < 30'(progLen)) ? prog[refPc[7:2]] : NOP;
    op = w[31:26];
    fn = w[5:0];
    a = refRegs[w[25:21]];
    b = refRegs[w[20:16]];
    imm = {{16{w[15]}}, w[15:0]};
    pc4 = refPc + 32'd4;
    nextPc = pc4;
    doWrite = 1'b1;
    dst = w[20:16];                     // rt unless r-type or jal
    res = '0;
    case (op)
      OP_RTYPE: begin
        dst = w[15:11];
        case (fn)
          FN_ADD:  res = a + b;
          FN_SUB:  res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLL:  res = b << w[10:6];
          FN_SRL:  res = b >> w[10:6];
          FN_JR: begin
            doWrite = 1'b0;
            nextPc = a;
          end
          default: doWrite = 1'b0;       // unknown funct is a nop
        endcase
      end
      OP_ADDI: res = a + imm;
      OP_LW: begin
        addr = a + imm;
        res = refMem[addr[DMEM_AW+1:2]];
      end
      OP_SW: begin
        addr = a + imm;
        refMem[addr[DMEM_AW+1:2]] = b;
        doWrite = 1'b0;
      end
      OP_BEQ: begin
        doWrite = 1'b0;
        if (a == b) nextPc = pc4 + (imm << 2);
      end
      OP_J: begin
        doWrite = 1'b0;
        nextPc = {pc4[31:28], w[25:0], 2'b00};
      end
      OP_JAL: begin
        dst = 5'd31;
        res = pc4;                       // no delay slot
        nextPc = {pc4[31:28], w[25:0], 2'b00};
      end
      default: doWrite = 1'b0;
    endcase
    expWb = '0;
    if (doWrite && (dst != '0)) begin
      expWb.valid = 1'b1;
      expWb.regIdx = dst;
      expWb.data = res;
      refRegs[dst] = res;
    end
  endtask

  // step DUT and model together until the model leaves the program
  task automatic runProgram();
    wbInfo_t expWb;
    word_t   nextPc;
    word_t   endAddr;
    int      steps;
    endAddr = word_t'(progLen * 4);
    steps = 0;
    while ((refPc != endAddr) && (steps < 4 * progLen)) begin
      @(negedge clk);
      checkPc(instrAddr, refPc);
      modelStep(expWb, nextPc);
      checkWb(wb, expWb);
      refPc = nextPc;
      steps++;
    end
    if (refPc != endAddr) begin
      $display("program did not reach its end address within %0d steps", steps);
      otherErrors++;
    end
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic resetHold();
    enterReset();
    emit(iType(OP_ADDI, 0, 1, 16'h0055));
    leaveReset(jType(OP_JAL, 5));        // jal held at pc 0 during reset
    runProgram();
  endtask

  task automatic arithOps();
    enterReset();
    emit(iType(OP_ADDI, 0, 1, randWord()));
    emit(iType(OP_ADDI, 0, 2, randWord()));
    emit(iType(OP_ADDI, 0, 3, -5));
    emit(iType(OP_ADDI, 0, 4, 7));
    emit(rType(1, 2, 5, 0, FN_ADD));
    emit(rType(1, 2, 6, 0, FN_SUB));
    emit(rType(1, 2, 7, 0, FN_AND));
    emit(rType(1, 2, 8, 0, FN_OR));
    emit(rType(3, 4, 9, 0, FN_SLT));     // negative vs positive
    emit(rType(4, 3, 10, 0, FN_SLT));
    emit(rType(1, 2, 11, 0, FN_SLT));
    emit(rType(0, 1, 12, 5'(randWord()), FN_SLL));
    emit(rType(0, 3, 13, 4, FN_SRL));    // zero fill of a negative value
    emit(rType(0, 2, 14, 31, FN_SLL));
    leaveReset(NOP);
    runProgram();
  endtask

  task automatic zeroRegister();
    enterReset();
    emit(iType(OP_ADDI, 0, 1, randWord()));
    emit(iType(OP_ADDI, 0, 0, 16'h007b));
    emit(rType(1, 1, 0, 0, FN_ADD));
    emit(rType(0, 1, 2, 0, FN_ADD));
    emit(rType(1, 0, 3, 0, FN_ADD));
    leaveReset(NOP);
    runProgram();
  endtask

  task automatic loadStore();
    enterReset();
    for (int r = 1; r <= 4; r++) emit(iType(OP_ADDI, 0, r, randWord()));
    emit(iType(OP_SW, 0, 1, 16'h0000));
    emit(iType(OP_SW, 0, 2, 16'h0008));
    emit(iType(OP_SW, 0, 3, 16'h001c));
    emit(iType(OP_SW, 0, 4, 16'h01fc)); // last word
    emit(iType(OP_LW, 0, 5, 16'h001c));
    emit(iType(OP_LW, 0, 6, 16'h01fc));
    emit(iType(OP_LW, 0, 7, 16'h0000));
    emit(iType(OP_LW, 0, 8, 16'h0008));
    emit(iType(OP_LW, 0, 9, 16'h0100)); // never written
    leaveReset(iType(OP_SW, 0, 0, 16'h0100));  // store held at pc 0 during reset
    runProgram();
  endtask

  task automatic controlFlow();
    enterReset();
    emit(iType(OP_ADDI, 0, 1, 5));       // 1
    emit(iType(OP_ADDI, 0, 2, 5));
    emit(iType(OP_ADDI, 0, 6, 3));
    emit(iType(OP_ADDI, 0, 9, 1));
    emit(iType(OP_BEQ, 1, 2, 1));        // 5, taken forward to 7
    emit(iType(OP_ADDI, 0, 3, 99));
    emit(iType(OP_BEQ, 1, 3, 5));        // 7, not taken
    emit(jType(OP_JAL, 11));             // 8, call
    emit(jType(OP_J, 16));               // 9, return lands here
    emit(iType(OP_ADDI, 0, 4, 1));
    emit(iType(OP_ADDI, 5, 5, 1));       // 11, loop body
    emit(rType(5, 6, 7, 0, FN_SLT));
    emit(iType(OP_BEQ, 7, 9, -3));       // 13, backward to 11
    emit(rType(31, 0, 0, 0, FN_JR));
    emit(iType(OP_ADDI, 0, 4, 2));
    emit(iType(OP_ADDI, 0, 4, 7));       // 16
    leaveReset(NOP);
    runProgram();
  endtask

  task automatic unsupportedOps();
    enterReset();
    emit(iType(OP_ADDI, 0, 1, randWord()));
    emit(iType(6'b111111, 1, 2, 16'h1234));
    emit(rType(1, 1, 3, 0, 6'b111111));
    emit(iType(6'b001101, 1, 4, 16'h00ff)); // ori, not in the subset
    emit(rType(1, 1, 5, 0, FN_ADD));
    leaveReset(NOP);
    runProgram();
  endtask

  initial begin
    for (int i = 0; i < `MIPS_DMEM_WORDS; i++) refMem[i] = '0;
    for (int i = 0; i < 64; i++) prog[i] = NOP;
    for (int i = 0; i < `MIPS_NREGS; i++) refRegs[i] = '0;
    resetHold();
    arithOps();
    zeroRegister();
    loadStore();
    controlFlow();
    unsupportedOps();
    otherErrors += dut_i.core_i.sva_i.assertFails;
    $display("errors: %0d wb, %0d instrAddr, %0d other", wbErrors, pcErrors, otherErrors);
    if ((wbErrors + pcErrors + otherErrors) == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mipsSubsys.f ====
+incdir+hw
hw/mipsIsaPkg.sv
hw/mipsBusPkg.sv
hw/controlDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/pcUnit.sv
hw/dataRam.sv
hw/mipsCore.sv
hw/mipsSubsys.sv
bench/mipsSva.sv
bench/mipsTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# compile and run the mipsSubsys testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module mipsTb \
  -f mipsSubsys.f --Mdir "$BUILD" -o mipsTb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/mipsTb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
